// File: source/hudCfg.svh
`ifndef HUD_CFG_SVH
`define HUD_CFG_SVH

// icon geometry, all three hearts share one row
`define HUD_ICON_SIZE 16
`define HUD_ICON_Y 11'd5
`define HUD_LEFT_X 11'd559
`define HUD_MID_X 11'd577
`define HUD_RIGHT_X 11'd595

`define HUD_INIT_LIVES 4'd3

// red 011 green 010 blue 11 in RGB332
`define HUD_HEART_COLOR 8'h6b
`define HUD_TRANSPARENT 8'hFF

// heart mask, bit 15 is the leftmost column of a row
`define HUD_HEART_ROW0 16'h0000
`define HUD_HEART_ROW1 16'h1C38
`define HUD_HEART_ROW2 16'h3E7C
`define HUD_HEART_ROW3 16'h7FFE
`define HUD_HEART_ROW4 16'h7FFE
`define HUD_HEART_ROW5 16'h7FFE
`define HUD_HEART_ROW6 16'h3FFC
`define HUD_HEART_ROW7 16'h3FFC
`define HUD_HEART_ROW8 16'h1FF8
`define HUD_HEART_ROW9 16'h0FF0
`define HUD_HEART_ROW10 16'h07E0
`define HUD_HEART_ROW11 16'h03C0
`define HUD_HEART_ROW12 16'h0180
`define HUD_HEART_ROW13 16'h0000
`define HUD_HEART_ROW14 16'h0000
`define HUD_HEART_ROW15 16'h0000

`endif

// File: source/displayPkg.sv
`default_nettype none

package displayPkg;

	// screen position of the current pixel, wide enough for 800x600 timing
	typedef logic [10:0] coordT;

	// position inside one 16x16 heart icon
	typedef logic [3:0] offsetT;

	// red 3 bits, green 3 bits, blue 2 bits in the usual RGB332 order
	typedef struct packed {
		logic [2:0] red;   // msb field of the byte
		logic [2:0] green;
		logic [1:0] blue;  // lsb field
	} rgb332T;

	// one colour byte seen either as a whole code or as its RGB332 fields
	typedef union packed {
		logic [7:0] raw;   // compared against the transparent code
		rgb332T rgb;       // used for channel expansion
	} colorT;

endpackage

`default_nettype wire

// File: source/gamePkg.sv
`default_nettype none

package gamePkg;

	// remaining lives, only 0 to 3 are ever shown
	typedef logic [3:0] livesT;

	// which heart icon a pixel belongs to
	typedef logic [1:0] iconIdxT;

	localparam iconIdxT ICON_LEFT = 2'd0;  // first to vanish
	localparam iconIdxT ICON_MID = 2'd1;
	localparam iconIdxT ICON_RIGHT = 2'd2; // last one standing
	localparam iconIdxT ICON_NONE = 2'd3;  // pixel outside every visible icon

endpackage

`default_nettype wire

// File: source/lifeCounter.sv
`default_nettype none
`timescale 1ns/10ps

`include "hudCfg.svh"

module lifeCounter (
	input logic clk,
	input logic resetN,
	input logic enable,             // low while the game is paused
	input logic dieReq,             // death request from the game core
	output logic dieAck,            // four-phase acknowledge
	output logic lostAllLifes,      // sticky, cleared only by reset
	output gamePkg::livesT lives
);

	logic serveReq;                 // a new request is taken this edge
	logic lastLife;                 // the request being served kills the last heart
	gamePkg::livesT livesNext;      // decremented count, never below zero

	// ack low means the previous handshake is finished,
	// so a held dieReq is counted once only
	assign serveReq = dieReq && enable && !dieAck;

	assign lastLife = (lives == 4'd1);

	// saturate so a death with no lives left keeps zero
	assign livesNext = (lives == 4'd0) ? lives : lives - 4'd1;

	// acknowledge flop
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			dieAck <= 1'b0;
		end
		else if (serveReq) begin
			dieAck <= 1'b1; // raise together with the decrement
		end
		else if (!dieReq) begin
			dieAck <= 1'b0; // requester released, close the handshake
		end
	end

	// life register
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			lives <= `HUD_INIT_LIVES;
		end
		else if (serveReq) begin
			lives <= livesNext;
		end
	end

	// loss flag goes up on the edge that takes lives to zero
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			lostAllLifes <= 1'b0;
		end
		else if (serveReq && lastLife) begin
			lostAllLifes <= 1'b1; // never cleared after this
		end
	end

endmodule

`default_nettype wire

// File: source/lifeIcons.sv
`default_nettype none
`timescale 1ns/10ps

`include "hudCfg.svh"

module lifeIcons (
	input logic clk,
	input logic resetN,
	input displayPkg::coordT pixelX,
	input displayPkg::coordT pixelY,
	input gamePkg::livesT lives,
	output logic hit,                          // pixel is inside a visible heart bracket
	output displayPkg::offsetT iconOffsetX,    // column inside that heart
	output displayPkg::offsetT iconOffsetY     // row inside that heart
);

	logic inRow;                               // pixelY within the icon strip
	logic showLeft;
	logic showMid;
	logic showRight;
	gamePkg::iconIdxT iconSel;                 // leftmost matching icon
	displayPkg::coordT cornerX;                // left edge of the selected icon
	displayPkg::coordT diffX;
	displayPkg::coordT diffY;

	// true when pos lies in [start, start + icon size)
	function automatic logic inSpan(
		input displayPkg::coordT pos,
		input displayPkg::coordT start
	);
		displayPkg::coordT stop;
		stop = start + displayPkg::coordT'(`HUD_ICON_SIZE);
		inSpan = (pos >= start) && (pos < stop);
	endfunction

	assign inRow = inSpan(pixelY, `HUD_ICON_Y);

	// hearts disappear from the left as lives run out
	assign showLeft = inRow && inSpan(pixelX, `HUD_LEFT_X) && (lives > 4'd2);
	assign showMid = inRow && inSpan(pixelX, `HUD_MID_X) && (lives > 4'd1);
	assign showRight = inRow && inSpan(pixelX, `HUD_RIGHT_X) && (lives > 4'd0);

	// brackets do not overlap today but keep the left one first anyway
	always_comb begin
		if (showLeft) begin
			iconSel = gamePkg::ICON_LEFT;
		end
		else if (showMid) begin
			iconSel = gamePkg::ICON_MID;
		end
		else if (showRight) begin
			iconSel = gamePkg::ICON_RIGHT;
		end
		else begin
			iconSel = gamePkg::ICON_NONE;
		end
	end

	always_comb begin
		case (iconSel)
			gamePkg::ICON_LEFT: cornerX = `HUD_LEFT_X;
			gamePkg::ICON_MID: cornerX = `HUD_MID_X;
			gamePkg::ICON_RIGHT: cornerX = `HUD_RIGHT_X;
			default: cornerX = `HUD_LEFT_X; // offset is zeroed on a miss
		endcase
	end

	assign diffX = pixelX - cornerX;       // only low 4 bits matter on a hit
	assign diffY = pixelY - `HUD_ICON_Y;

	// stage one register
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hit <= 1'b0;
			iconOffsetX <= '0;
			iconOffsetY <= '0;
		end
		else if (iconSel != gamePkg::ICON_NONE) begin
			hit <= 1'b1;
			iconOffsetX <= diffX[3:0];
			iconOffsetY <= diffY[3:0];
		end
		else begin
			hit <= 1'b0;
			iconOffsetX <= '0; // no icon, no offset
			iconOffsetY <= '0;
		end
	end

endmodule

`default_nettype wire

// File: source/heartBitmap.sv
`default_nettype none
`timescale 1ns/10ps

`include "hudCfg.svh"

module heartBitmap (
	input logic clk,
	input logic resetN,
	input logic hit,                         // from stage one
	input displayPkg::offsetT iconOffsetX,
	input displayPkg::offsetT iconOffsetY,
	output displayPkg::colorT iconColor      // heart colour or transparent
);

	logic [15:0] maskRow;    // row of the heart picked by iconOffsetY
	logic maskBit;           // column bit, msb is x = 0

	// small ROM built from the cfg rows
	always_comb begin
		case (iconOffsetY)
			4'd0: maskRow = `HUD_HEART_ROW0;
			4'd1: maskRow = `HUD_HEART_ROW1;
			4'd2: maskRow = `HUD_HEART_ROW2;
			4'd3: maskRow = `HUD_HEART_ROW3;
			4'd4: maskRow = `HUD_HEART_ROW4;
			4'd5: maskRow = `HUD_HEART_ROW5;
			4'd6: maskRow = `HUD_HEART_ROW6;
			4'd7: maskRow = `HUD_HEART_ROW7;
			4'd8: maskRow = `HUD_HEART_ROW8;
			4'd9: maskRow = `HUD_HEART_ROW9;
			4'd10: maskRow = `HUD_HEART_ROW10;
			4'd11: maskRow = `HUD_HEART_ROW11;
			4'd12: maskRow = `HUD_HEART_ROW12;
			4'd13: maskRow = `HUD_HEART_ROW13;
			4'd14: maskRow = `HUD_HEART_ROW14;
			default: maskRow = `HUD_HEART_ROW15;
		endcase
	end

	assign maskBit = maskRow[4'd15 - iconOffsetX]; // flip so x = 0 reads bit 15

	// stage two register
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			iconColor.raw <= `HUD_TRANSPARENT; // nothing drawn out of reset
		end
		else if (hit && maskBit) begin
			iconColor.raw <= `HUD_HEART_COLOR;
		end
		else begin
			iconColor.raw <= `HUD_TRANSPARENT; // outside the heart shape
		end
	end

endmodule

`default_nettype wire

// File: source/hudMux.sv
`default_nettype none
`timescale 1ns/10ps

`include "hudCfg.svh"

module hudMux (
	input logic clk,
	input logic resetN,
	input displayPkg::colorT iconColor,   // from stage two
	input displayPkg::colorT bgColor,     // arrives with the pixel, two stages early
	output logic [3:0] vgaR,
	output logic [3:0] vgaG,
	output logic [3:0] vgaB,
	output logic hudDrawing               // a heart pixel is on the channels
);

	displayPkg::colorT bgDly1;            // matches stage one
	displayPkg::colorT bgDly2;            // matches stage two
	displayPkg::colorT selColor;
	logic drawIcon;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			bgDly1 <= '0;
			bgDly2 <= '0;
		end
		else begin
			bgDly1 <= bgColor;
			bgDly2 <= bgDly1;
		end
	end

	assign drawIcon = (iconColor.raw != `HUD_TRANSPARENT); // raw byte view
	assign selColor = drawIcon ? iconColor : bgDly2;

	// stage three, RGB332 to 4 bits per channel by repeating the top bits
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			vgaR <= '0;
			vgaG <= '0;
			vgaB <= '0;
			hudDrawing <= 1'b0;
		end
		else begin
			vgaR <= {selColor.rgb.red, selColor.rgb.red[2]};
			vgaG <= {selColor.rgb.green, selColor.rgb.green[2]};
			vgaB <= {selColor.rgb.blue, selColor.rgb.blue}; // 2 bits doubled
			hudDrawing <= drawIcon;
		end
	end

endmodule

`default_nettype wire

// File: source/hudTop.sv
`default_nettype none
`timescale 1ns/10ps

module hudTop (
	input logic clk,
	input logic resetN,
	input logic enable,
	input logic dieReq,
	input displayPkg::coordT pixelX,
	input displayPkg::coordT pixelY,
	input displayPkg::colorT bgColor,
	output logic dieAck,
	output logic lostAllLifes,
	output gamePkg::livesT lives,
	output logic [3:0] vgaR,
	output logic [3:0] vgaG,
	output logic [3:0] vgaB,
	output logic hudDrawing
);

	logic hit;                            // stage one to two
	displayPkg::offsetT iconOffsetX;
	displayPkg::offsetT iconOffsetY;
	displayPkg::colorT iconColor;         // stage two to three

	lifeCounter counterInst (
		.clk(clk),
		.resetN(resetN),
		.enable(enable),
		.dieReq(dieReq),
		.dieAck(dieAck),
		.lostAllLifes(lostAllLifes),
		.lives(lives)
	);

	lifeIcons iconsInst (
		.clk(clk),
		.resetN(resetN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.lives(lives),                    // same count the game sees
		.hit(hit),
		.iconOffsetX(iconOffsetX),
		.iconOffsetY(iconOffsetY)
	);

	heartBitmap bitmapInst (
		.clk(clk),
		.resetN(resetN),
		.hit(hit),
		.iconOffsetX(iconOffsetX),
		.iconOffsetY(iconOffsetY),
		.iconColor(iconColor)
	);

	hudMux muxInst (
		.clk(clk),
		.resetN(resetN),
		.iconColor(iconColor),
		.bgColor(bgColor),                // delayed inside the mux
		.vgaR(vgaR),
		.vgaG(vgaG),
		.vgaB(vgaB),
		.hudDrawing(hudDrawing)
	);

endmodule

`default_nettype wire

// File: tests/hudTop_sva.sv
`default_nettype none
`timescale 1ns/10ps

`include "hudCfg.svh"

module hudTopSva (
	input logic clk,
	input logic resetN,
	input logic dieReq,
	input logic dieAck,
	input logic lostAllLifes,
	input gamePkg::livesT lives
);

	int assertFails = 0;

	// ack only answers a request seen at the edge that set it
	ackNeedsReq: assert property (@(posedge clk) disable iff (!resetN)
		$rose(dieAck) |-> $past(dieReq)) else begin
		assertFails++;
		$error("dieAck rose without a pending dieReq");
	end

	ackHeld: assert property (@(posedge clk) disable iff (!resetN)
		$fell(dieAck) |-> !$past(dieReq)) else begin
		assertFails++;
		$error("dieAck fell while dieReq was still high");
	end

	lossSticky: assert property (@(posedge clk) disable iff (!resetN)
		!$fell(lostAllLifes)) else begin
		assertFails++;
		$error("lostAllLifes dropped without a reset");
	end

	// a zero count may stay put on an ack, the other way round is illegal
	livesOnAck: assert property (@(posedge clk) disable iff (!resetN)
		$changed(lives) |-> $rose(dieAck)) else begin
		assertFails++;
		$error("lives changed outside an acknowledge");
	end

	resetState: assert property (@(posedge clk)
		$rose(resetN) |-> (lives == `HUD_INIT_LIVES) && !dieAck && !lostAllLifes) else begin
		assertFails++;
		$error("life counter left reset in the wrong state");
	end

endmodule

`default_nettype wire

// File: tests/hudChecker.sv
`default_nettype none
`timescale 1ns/10ps

`include "hudCfg.svh"

module hudChecker (
	input logic clk,
	input logic resetN,
	input logic enable,
	input logic dieReq,
	input displayPkg::coordT pixelX,
	input displayPkg::coordT pixelY,
	input displayPkg::colorT bgColor,
	input logic dieAck,
	input logic lostAllLifes,
	input gamePkg::livesT lives,
	input logic [3:0] vgaR,
	input logic [3:0] vgaG,
	input logic [3:0] vgaB,
	input logic hudDrawing,
	input logic testDone,
	input int testIdx,
	input gamePkg::livesT expLives,      // count the data file expects at test end
	output int errCount,
	output int testCount,
	output int failCount
);

	logic [15:0] heartRows [16];
	gamePkg::livesT modelLives;
	logic modelAck;
	logic modelLost;
	logic [12:0] pipeQ [$];              // {drawing, r, g, b}, three pixels in flight
	logic [12:0] expPix;
	int errs = 0;
	int tests = 0;
	int fails = 0;
	int errMark = 0;                     // errors seen before the current test

	assign errCount = errs;
	assign testCount = tests;
	assign failCount = fails;

	initial begin
		heartRows = '{`HUD_HEART_ROW0, `HUD_HEART_ROW1, `HUD_HEART_ROW2, `HUD_HEART_ROW3,
			`HUD_HEART_ROW4, `HUD_HEART_ROW5, `HUD_HEART_ROW6, `HUD_HEART_ROW7,
			`HUD_HEART_ROW8, `HUD_HEART_ROW9, `HUD_HEART_ROW10, `HUD_HEART_ROW11,
			`HUD_HEART_ROW12, `HUD_HEART_ROW13, `HUD_HEART_ROW14, `HUD_HEART_ROW15};
	end

	// inside the square whose top-left column is left
	function automatic logic inIcon(
		input displayPkg::coordT x,
		input displayPkg::coordT y,
		input displayPkg::coordT left
	);
		inIcon = (x >= left) && (x - left < 11'(`HUD_ICON_SIZE))
			&& (y >= `HUD_ICON_Y) && (y - `HUD_ICON_Y < 11'(`HUD_ICON_SIZE));
	endfunction

	// expected {drawing, r, g, b} for one pixel at a given life count
	function automatic logic [12:0] pixelModel(
		input displayPkg::coordT x,
		input displayPkg::coordT y,
		input logic [7:0] bg,
		input gamePkg::livesT n
	);
		displayPkg::coordT left;
		logic [3:0] ox;
		logic [3:0] oy;
		logic found;
		logic draw;
		logic [7:0] c;
		found = 1'b1;
		if (n >= 4'd3 && inIcon(x, y, `HUD_LEFT_X)) begin
			left = `HUD_LEFT_X;
		end
		else if (n >= 4'd2 && inIcon(x, y, `HUD_MID_X)) begin
			left = `HUD_MID_X;
		end
		else if (n >= 4'd1 && inIcon(x, y, `HUD_RIGHT_X)) begin
			left = `HUD_RIGHT_X;
		end
		else begin
			left = '0;
			found = 1'b0;
		end
		ox = 4'(x - left);
		oy = 4'(y - `HUD_ICON_Y);
		draw = found && heartRows[oy][4'd15 - ox];     // column 0 sits in bit 15
		c = draw ? `HUD_HEART_COLOR : bg;
		pixelModel = {draw, c[7:5], c[7], c[4:2], c[4], c[1:0], c[1:0]};
	endfunction

	task automatic checkOut(input string what, input int got, input int want);
		if (got != want) begin
			$display("Fail %0t: %s is %0h, expected %0h", $time, what, got, want);
			errs++;
		end
	endtask

	// outputs are settled at the falling edge, inputs are those for the next rise
	always @(negedge clk) begin
		if (!resetN) begin
			modelLives = `HUD_INIT_LIVES;
			modelAck = 1'b0;
			modelLost = 1'b0;
			pipeQ = '{13'd0, 13'd0, 13'd0};              // all stages hold zero in reset
			expPix = 13'd0;
		end
		else begin
			expPix = pipeQ.pop_front();
		end
		checkOut("lives", int'(lives), int'(modelLives));
		checkOut("dieAck", int'(dieAck), int'(modelAck));
		checkOut("lostAllLifes", int'(lostAllLifes), int'(modelLost));
		checkOut("hudDrawing", int'(hudDrawing), int'(expPix[12]));
		checkOut("vga rgb", int'({vgaR, vgaG, vgaB}), int'(expPix[11:0]));
		if (resetN) begin
			pipeQ.push_back(pixelModel(pixelX, pixelY, bgColor.raw, modelLives));
			if (dieReq && enable && !modelAck) begin         // death taken at the next edge
				modelAck = 1'b1;
				modelLost = modelLost || (modelLives == 4'd1);
				modelLives = (modelLives == 4'd0) ? 4'd0 : modelLives - 4'd1;
			end
			else if (!dieReq) begin
				modelAck = 1'b0;
			end
		end
		if (testDone) begin
			tests++;
			checkOut("lives at test end", int'(lives), int'(expLives));
			if (errs == errMark) begin
				$display("test %0d passed, lives %0d", testIdx, lives);
			end
			else begin
				$display("test %0d failed with %0d errors", testIdx, errs - errMark);
				fails++;
			end
			errMark = errs;
		end
	end

endmodule

`default_nettype wire

// File: tests/hudTb.sv
`default_nettype none
`timescale 1ns/10ps

module hudTb;

	logic clk = 1'b0;
	logic resetN;
	logic enable;
	logic dieReq;
	displayPkg::coordT pixelX;
	displayPkg::coordT pixelY;
	displayPkg::colorT bgColor;
	logic dieAck;
	logic lostAllLifes;
	gamePkg::livesT lives;
	logic [3:0] vgaR;
	logic [3:0] vgaG;
	logic [3:0] vgaB;
	logic hudDrawing;
	logic testDone;                       // one-cycle strobe at the end of each test
	int testIdx;
	gamePkg::livesT expLives;
	int errCount;
	int testCount;
	int failCount;
	logic [15:0] vecMem [0:191];          // six hex words per line of the data file
	int seed = 32'hddf;
	int cycles = 0;
	int cycleLimit = 1000000;             // tightened once the file is read

	hudTop UUT (.*);

	hudChecker checkInst (.*);

	bind hudTop hudTopSva assertInst (
		.clk(clk),
		.resetN(resetN),
		.dieReq(dieReq),
		.dieAck(dieAck),
		.lostAllLifes(lostAllLifes),
		.lives(lives)
	);

	always #10 clk = ~clk;                // 20 ns period

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycleLimit) begin
			$display("timeout: the tests did not finish within %0d clock cycles", cycleLimit);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic logic [15:0] vecWord(input int line, input int col);
		vecWord = vecMem[6 * line + col];
	endfunction

	task automatic nextCycle;
		@(posedge clk);
		#2;                               // inputs move just after the edge
	endtask

	task automatic endTest(input int idx, input logic [15:0] want);
		testIdx = idx;
		expLives = 4'(want);
		testDone = 1'b1;
		nextCycle();
		testDone = 1'b0;
	endtask

	// one full four-phase handshake, optionally paused before it is served
	task automatic runDeath(input int lowCycles, input int holdCycles);
		enable = (lowCycles == 0);
		dieReq = 1'b1;
		repeat (lowCycles) nextCycle();
		enable = 1'b1;
		do nextCycle(); while (!dieAck);
		repeat (holdCycles) nextCycle();  // keep requesting long after the ack
		dieReq = 1'b0;
		do nextCycle(); while (dieAck);
		nextCycle();
	endtask

	// one row of pixels, then idle pixels until the pipeline has drained
	task automatic runScan(
		input displayPkg::coordT row,
		input displayPkg::coordT xFrom,
		input displayPkg::coordT xTo,
		input logic [15:0] bg
	);
		displayPkg::coordT x;
		x = xFrom;
		pixelY = row;
		while (x <= xTo) begin
			pixelX = x;
			bgColor.raw = bg[8] ? 8'($random(seed)) : bg[7:0]; // bit 8 marks random colour
			nextCycle();
			x = x + 11'd1;
		end
		pixelX = '0;
		pixelY = '0;
		bgColor.raw = '0;
		repeat (4) nextCycle();
	endtask

	initial begin
		int line;
		int total;
		resetN = 1'b0;
		enable = 1'b1;
		dieReq = 1'b0;
		pixelX = '0;
		pixelY = '0;
		bgColor.raw = '0;
		testDone = 1'b0;
		testIdx = 0;
		expLives = '0;
		$readmemh("tests/hudInput.txt", vecMem);
		total = 5;
		line = 0;
		while (vecWord(line, 0) != 16'd0) begin
			if (vecWord(line, 0) == 16'd1) begin
				total += int'(vecWord(line, 1)) + int'(vecWord(line, 2)) + 8;
			end
			else begin
				total += int'(vecWord(line, 3)) - int'(vecWord(line, 2)) + 8;
			end
			line++;
		end
		cycleLimit = total + 100;
		repeat (5) nextCycle();
		resetN = 1'b1;
		line = 0;
		while (vecWord(line, 0) != 16'd0) begin
			if (vecWord(line, 0) == 16'd1) begin
				runDeath(int'(vecWord(line, 1)), int'(vecWord(line, 2)));
				endTest(line + 1, vecWord(line, 3));
			end
			else begin
				runScan(11'(vecWord(line, 1)), 11'(vecWord(line, 2)), 11'(vecWord(line, 3)),
					vecWord(line, 4));
				endTest(line + 1, vecWord(line, 5));
			end
			line++;
		end
		repeat (2) nextCycle();
		$display("tests %0d, failed %0d, value errors %0d, assertion failures %0d",
			testCount, failCount, errCount, UUT.assertInst.assertFails);
		if (failCount == 0 && errCount == 0 && UUT.assertInst.assertFails == 0) begin
			$display(">>> PASS");
		end
		else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/hudInput.txt
// kind 1 death: enableLowCycles reqHoldCycles expLives 0 0
// kind 2 scan: row xFrom xTo bgColor expLives, bgColor 100 means random per pixel
2 064 000 014 100 3 // far from the hearts
2 006 22F 262 025 3 // three hearts, top of the shape
2 009 22F 262 0E2 3
2 00F 22F 262 025 3
1 000 008 002 0 0   // request held long after the ack
2 008 22F 262 049 2
2 00D 22F 262 100 2
1 005 003 001 0 0   // paused for five cycles first
2 00A 22F 262 025 1
2 011 22F 262 0B6 1
1 000 004 000 0 0   // last life goes, loss flag rises
2 00A 22F 262 025 0
1 002 002 000 0 0   // death with no lives left
2 014 22F 262 100 0 // bottom mask row
2 004 22F 262 100 0 // one row above the strip
2 12C 064 082 100 0 // random background only
0 000 000 000 0 0

// File: flist.f
+incdir+source
source/displayPkg.sv
source/gamePkg.sv
source/lifeCounter.sv
source/lifeIcons.sv
source/heartBitmap.sv
source/hudMux.sv
source/hudTop.sv
tests/hudTop_sva.sv
tests/hudChecker.sv
tests/hudTb.sv

// File: Makefile
TOP = hudTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+1000 2>&1 | tee sim.log
	@if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log
